//--- logic/fe_defines.svh
// fetch front end global widths and constants
// shared by the package and the RTL blocks

`ifndef FE_DEFINES_SVH
`define FE_DEFINES_SVH

// pc and data width
`define FE_XLEN 32

// instruction memory read window
`define FE_MEM_W 32

// boot address
`define FE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define FE_NOP 32'h0000_0013

`endif

//--- logic/fe_pkg.sv
// fetch front end types
// opcode encoding plus the IF/ID and ID result payloads

`include "fe_defines.svh"

package fe_pkg;

  // major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  typedef struct packed {
    logic [`FE_XLEN-1:0]  pc;
    logic [`FE_MEM_W-1:0] instr;       // low half only when compressed
    logic                 compressed;
    logic                 br;
    logic                 br_taken;    // no predictor yet
    logic                 jump;        // predecoded in IF
  } if_id_t;

  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    opcode_e             opcode;
    logic [4:0]          rd;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [`FE_XLEN-1:0] imm;          // sign extended
    logic                compressed;
    logic                br;
    logic                illegal;
  } decoded_t;

endpackage : fe_pkg

//--- logic/if_id_if.sv
// IF to ID pipeline link
// one payload per cycle, no handshake

`timescale 1ns/1ps

interface if_id_if;

  fe_pkg::if_id_t payload;

  // fetch side
  modport producer (
    output payload
  );

  // decode side
  modport consumer (
    input payload
  );

endinterface : if_id_if

//--- logic/jump_predecoder.sv
// jump predecoder for the fetch stage
// spots JAL, C.J and conditional branches and builds the jump offset

`timescale 1ns/1ps

`include "fe_defines.svh"

module jump_predecoder (
  input  logic [`FE_MEM_W-1:0] window,
  output logic                 j,
  output logic                 br,
  output logic [`FE_XLEN-1:0]  jimm
);

  logic                compressed;
  logic [6:0]          opcode;
  logic [1:0]          quadrant;
  logic [2:0]          funct3_c;
  logic                is_jal;
  logic                is_cj;
  logic                is_branch;
  logic                is_cbranch;
  logic [`FE_XLEN-1:0] jal_off;
  logic [`FE_XLEN-1:0] cj_off;

  assign quadrant   = window[1:0];
  assign compressed = (quadrant != 2'b11);
  assign opcode     = window[6:0];
  assign funct3_c   = window[15:13];

  // full size encodings
  assign is_jal    = !compressed && (opcode == fe_pkg::JAL);
  assign is_branch = !compressed && (opcode == fe_pkg::BRANCH);

  // quadrant 1: c.j is 101, c.beqz 110, c.bnez 111
  assign is_cj      = (quadrant == 2'b01) && (funct3_c == 3'b101);
  assign is_cbranch = (quadrant == 2'b01) && (funct3_c[2:1] == 2'b11);

  // J-type offset
  assign jal_off = {{12{window[31]}}, window[19:12], window[20], window[30:21], 1'b0};

  // CJ-type offset, scrambled imm[11|4|9:8|10|6|7|3:1|5]
  assign cj_off = {{20{window[12]}},
                   window[12],      // imm[11]
                   window[8],       // imm[10]
                   window[10:9],    // imm[9:8]
                   window[6],       // imm[7]
                   window[7],       // imm[6]
                   window[2],       // imm[5]
                   window[11],      // imm[4]
                   window[5:3],     // imm[3:1]
                   1'b0};

  assign j    = is_jal || is_cj;
  assign br   = is_branch || is_cbranch;
  assign jimm = compressed ? cj_off : jal_off;

endmodule : jump_predecoder

//--- logic/if_stage.sv
// fetch stage
// holds the pc, predecodes jumps and fills the IF/ID register

`timescale 1ns/1ps

`include "fe_defines.svh"

module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`FE_MEM_W-1:0] mem_rd,
  input  logic [`FE_XLEN-1:0]  pc_in,
  input  logic                 pc_update,
  output logic [`FE_XLEN-1:0]  pc_out,
  if_id_if.producer            if_id
);

  logic [`FE_XLEN-1:0] pc;
  logic [`FE_XLEN-1:0] next_pc;
  logic [`FE_XLEN-1:0] jimm;
  logic                compressed;
  logic                j;
  logic                br;

  jump_predecoder jump_predecoder_inst (
    .window (mem_rd),
    .j      (j),
    .br     (br),
    .jimm   (jimm)
  );

  assign compressed = (mem_rd[1:0] != 2'b11);
  assign pc_out     = pc;

  // redirect wins over jump, jump over sequential
  always_comb begin
    if (pc_update) begin
      next_pc = pc_in;
    end else if (j) begin
      next_pc = pc + jimm;
    end else begin
      next_pc = pc + (compressed ? `FE_XLEN'(2) : `FE_XLEN'(4));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc            <= `FE_RESET_PC;
      if_id.payload <= '0; // instr 0 decodes as illegal
    end else begin
      pc                       <= {next_pc[`FE_XLEN-1:1], 1'b0}; // halfword aligned
      if_id.payload.pc         <= pc;
      if_id.payload.br_taken   <= 1'b0;
      if (pc_update) begin
        // squash the slot being fetched
        if_id.payload.instr      <= `FE_NOP;
        if_id.payload.compressed <= 1'b0;
        if_id.payload.br         <= 1'b0;
        if_id.payload.jump       <= 1'b0;
      end else begin
        if_id.payload.instr      <= mem_rd;
        if_id.payload.compressed <= compressed;
        if_id.payload.br         <= br;
        if_id.payload.jump       <= j; // jump goes down as itself
      end
    end
  end

  // later stages only redirect to halfword boundaries
  a_pc_in_aligned : assert property (
    @(posedge clk) disable iff (!rst_n) pc_update |-> !pc_in[0]
  ) else $error("if_stage: misaligned redirect target %h", pc_in);

endmodule : if_stage

//--- logic/c_expander.sv
// compressed instruction expander
// rebuilds the supported RVC subset as 32-bit words, rest is illegal

`timescale 1ns/1ps

`include "fe_defines.svh"

module c_expander (
  input  logic [15:0] half,
  output logic [31:0] instr,
  output logic        illegal
);

  logic [1:0]  quadrant;
  logic [2:0]  funct3;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm6;
  logic [20:0] j_off;

  assign quadrant = half[1:0];
  assign funct3   = half[15:13];
  assign rd       = half[11:7];
  assign rs2      = half[6:2];

  // c.addi / c.li immediate, sign extended to 12 bits
  assign imm6 = {{6{half[12]}}, half[12], half[6:2]};

  // c.j offset widened to the JAL range
  assign j_off = {{9{half[12]}},
                  half[12],
                  half[8],
                  half[10:9],
                  half[6],
                  half[7],
                  half[2],
                  half[11],
                  half[5:3],
                  1'b0};

  always_comb begin
    instr   = `FE_NOP;
    illegal = 1'b1;
    case (quadrant)
      2'b01: begin
        case (funct3)
          3'b000: begin // c.addi, c.nop when rd is x0
            instr   = {imm6, rd, 3'b000, rd, fe_pkg::OP_IMM};
            illegal = 1'b0;
          end
          3'b010: begin // c.li
            instr   = {imm6, 5'd0, 3'b000, rd, fe_pkg::OP_IMM};
            illegal = 1'b0;
          end
          3'b101: begin // c.j -> jal x0
            instr   = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                       5'd0, fe_pkg::JAL};
            illegal = 1'b0;
          end
          default: ;
        endcase
      end
      2'b10: begin
        // rs2 of x0 would be c.jr / c.jalr / c.ebreak
        if (funct3 == 3'b100 && rs2 != 5'd0) begin
          if (!half[12]) begin // c.mv
            instr = {7'b0000000, rs2, 5'd0, 3'b000, rd, fe_pkg::OP};
          end else begin       // c.add
            instr = {7'b0000000, rs2, rd, 3'b000, rd, fe_pkg::OP};
          end
          illegal = 1'b0;
        end
      end
      default: ; // quadrant 0 not supported
    endcase
  end

endmodule : c_expander

//--- logic/id_stage.sv
// decode stage
// expands compressed words, pulls out fields and registers the result

`timescale 1ns/1ps

`include "fe_defines.svh"

module id_stage (
  input  logic              clk,
  input  logic              rst_n,
  if_id_if.consumer         if_id,
  output fe_pkg::decoded_t  dec
);

  logic [31:0]         exp_instr;
  logic                exp_illegal;
  logic [31:0]         raw;
  logic [31:0]         word;
  logic                known_op;
  logic                illegal;
  logic [`FE_XLEN-1:0] imm;
  fe_pkg::decoded_t    dec_d;

  c_expander c_expander_inst (
    .half    (if_id.payload.instr[15:0]),
    .instr   (exp_instr),
    .illegal (exp_illegal)
  );

  assign raw = if_id.payload.compressed ? exp_instr : if_id.payload.instr;

  always_comb begin
    case (raw[6:0])
      fe_pkg::OP_IMM, fe_pkg::OP, fe_pkg::LUI, fe_pkg::JAL,
      fe_pkg::JALR, fe_pkg::BRANCH, fe_pkg::LOAD, fe_pkg::STORE: known_op = 1'b1;
      default: known_op = 1'b0;
    endcase
  end

  assign illegal = (if_id.payload.compressed && exp_illegal) || !known_op;
  assign word    = illegal ? `FE_NOP : raw; // illegal slots look like a nop

  // J immediate for jal, I immediate otherwise
  assign imm = (word[6:0] == fe_pkg::JAL) ?
               {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0} :
               {{20{word[31]}}, word[31:20]};

  always_comb begin
    dec_d.pc         = if_id.payload.pc;
    dec_d.opcode     = fe_pkg::opcode_e'(word[6:0]);
    dec_d.rd         = word[11:7];
    dec_d.rs1        = word[19:15];
    dec_d.rs2        = word[24:20];
    dec_d.imm        = imm;
    dec_d.compressed = if_id.payload.compressed;
    dec_d.br         = if_id.payload.br;
    dec_d.illegal    = illegal;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec <= dec_d;
    end
  end

  // IF predecode and ID decode must agree on jumps
  a_jump_is_jal : assert property (
    @(posedge clk) disable iff (!rst_n) if_id.payload.jump |-> (raw[6:0] == fe_pkg::JAL)
  ) else $error("id_stage: predecoded jump at %h is not a jal", if_id.payload.pc);

endmodule : id_stage

//--- logic/fetch_frontend.sv
// fetch front end top
// IF and ID stages behind plain ports

`timescale 1ns/1ps

`include "fe_defines.svh"

module fetch_frontend (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`FE_MEM_W-1:0] mem_rd,
  output logic [`FE_XLEN-1:0]  pc_out,
  input  logic [`FE_XLEN-1:0]  pc_in,
  input  logic                 pc_update,
  output logic [`FE_XLEN-1:0]  dec_pc,
  output logic [6:0]           dec_opcode,
  output logic [4:0]           dec_rd,
  output logic [4:0]           dec_rs1,
  output logic [4:0]           dec_rs2,
  output logic [`FE_XLEN-1:0]  dec_imm,
  output logic                 dec_compressed,
  output logic                 dec_br,
  output logic                 dec_illegal
);

  fe_pkg::decoded_t dec;

  if_id_if if_id_inst ();

  if_stage if_stage_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_rd    (mem_rd),
    .pc_in     (pc_in),
    .pc_update (pc_update),
    .pc_out    (pc_out),
    .if_id     (if_id_inst)
  );

  id_stage id_stage_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .if_id (if_id_inst),
    .dec   (dec)
  );

  // flatten the decoded struct
  assign dec_pc         = dec.pc;
  assign dec_opcode     = dec.opcode;
  assign dec_rd         = dec.rd;
  assign dec_rs1        = dec.rs1;
  assign dec_rs2        = dec.rs2;
  assign dec_imm        = dec.imm;
  assign dec_compressed = dec.compressed;
  assign dec_br         = dec.br;
  assign dec_illegal    = dec.illegal;

endmodule : fetch_frontend

//--- bench/fe_tb_pkg.svh
// fetch front end testbench helpers
// program image, expected decode per address and the compare tasks

`ifndef FE_TB_PKG_SVH
`define FE_TB_PKG_SVH

typedef struct {
  logic [31:0]      pc;       // expected pc_out in this cycle
  logic             upd;      // redirect driven in this cycle
  logic [31:0]      pc_in;
  fe_pkg::decoded_t exp;      // expected decode two edges later
} row_t;

// halfword image, unused space filled from the address
task automatic load_program();
  for (int i = 0; i < 256; i++) begin
    mem[i] = 16'h5a5a ^ {i[7:0], i[7:0]};
  end
  mem[0]  = 16'h0093;                     // addi x1, x0, 5
  mem[1]  = 16'h0050;
  mem[2]  = 16'h5175;                     // c.li x2, -3
  mem[3]  = 16'h0085;                     // c.addi x1, 1
  mem[4]  = 16'h818a;                     // c.mv x3, x2
  mem[5]  = 16'h9186;                     // c.add x3, x1
  mem[6]  = 16'h0001;                     // c.nop
  mem[7]  = 16'h8463;                     // beq x1, x2, +8
  mem[8]  = 16'h0020;
  mem[9]  = 16'h00ef;                     // jal x1, +12
  mem[10] = 16'h00c0;
  mem[15] = 16'ha011;                     // c.j +4
  mem[17] = 16'h4000;                     // quadrant 0, unsupported
  mem[18] = 16'h12b7;                     // lui x5, 1
  mem[19] = 16'h0000;
  mem[20] = 16'hf06f;                     // jal x0, -40
  mem[21] = 16'hfd9f;
endtask

function automatic fe_pkg::decoded_t mk(input logic [31:0] pc, input fe_pkg::opcode_e op,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm,
                                         input logic c, input logic br, input logic ill);
  fe_pkg::decoded_t d;
  d.pc = pc;
  d.opcode = op;
  d.rd = rd;
  d.rs1 = rs1;
  d.rs2 = rs2;
  d.imm = imm;
  d.compressed = c;
  d.br = br;
  d.illegal = ill;
  return d;
endfunction

// squashed slot after a redirect
function automatic fe_pkg::decoded_t nop_slot(input logic [31:0] pc);
  return mk(pc, fe_pkg::OP_IMM, 5'd0, 5'd0, 5'd0, 32'd0, 1'b0, 1'b0, 1'b0);
endfunction

`endif

//--- bench/fetch_frontend_tb.sv
// fetch front end testbench
// table of fetch cycles with redirects, checked on pc_out and the decode outputs

`timescale 1ns/1ps

module fetch_frontend_tb;

  logic        clk;
  logic        rst_n;
  logic [31:0] mem_rd;
  logic [31:0] pc_out;
  logic [31:0] pc_in;
  logic        pc_update;
  logic [31:0] dec_pc;
  logic [6:0]  dec_opcode;
  logic [4:0]  dec_rd;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [31:0] dec_imm;
  logic        dec_compressed;
  logic        dec_br;
  logic        dec_illegal;

  logic [15:0] mem [0:255];

  `include "fe_tb_pkg.svh"

  row_t        rows [$];
  int          value_errors;
  int          other_errors;

  fetch_frontend fetch_frontend_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_rd         (mem_rd),
    .pc_out         (pc_out),
    .pc_in          (pc_in),
    .pc_update      (pc_update),
    .dec_pc         (dec_pc),
    .dec_opcode     (dec_opcode),
    .dec_rd         (dec_rd),
    .dec_rs1        (dec_rs1),
    .dec_rs2        (dec_rs2),
    .dec_imm        (dec_imm),
    .dec_compressed (dec_compressed),
    .dec_br         (dec_br),
    .dec_illegal    (dec_illegal)
  );

  always #20 clk = ~clk;

  // zero latency memory, two halfwords at the pc
  function automatic logic [31:0] fetch_window(input logic [31:0] addr);
    logic [7:0] idx;
    idx = addr[8:1];
    return {mem[idx + 8'd1], mem[idx]};
  endfunction

  // hand decoded result of each program address
  function automatic fe_pkg::decoded_t exp_at(input logic [31:0] a);
    case (a)
      32'h00: return mk(a, fe_pkg::OP_IMM, 5'd1, 5'd0, 5'd5, 32'd5, 1'b0, 1'b0, 1'b0);
      32'h04: return mk(a, fe_pkg::OP_IMM, 5'd2, 5'd0, 5'd29, 32'hffff_fffd,
                        1'b1, 1'b0, 1'b0);
      32'h06: return mk(a, fe_pkg::OP_IMM, 5'd1, 5'd1, 5'd1, 32'd1, 1'b1, 1'b0, 1'b0);
      32'h08: return mk(a, fe_pkg::OP, 5'd3, 5'd0, 5'd2, 32'd2, 1'b1, 1'b0, 1'b0);
      32'h0a: return mk(a, fe_pkg::OP, 5'd3, 5'd3, 5'd1, 32'd1, 1'b1, 1'b0, 1'b0);
      32'h0c: return mk(a, fe_pkg::OP_IMM, 5'd0, 5'd0, 5'd0, 32'd0, 1'b1, 1'b0, 1'b0);
      32'h0e: return mk(a, fe_pkg::BRANCH, 5'd8, 5'd1, 5'd2, 32'd2, 1'b0, 1'b1, 1'b0);
      32'h12: return mk(a, fe_pkg::JAL, 5'd1, 5'd0, 5'd12, 32'd12, 1'b0, 1'b0, 1'b0);
      32'h1e: return mk(a, fe_pkg::JAL, 5'd0, 5'd0, 5'd4, 32'd4, 1'b1, 1'b0, 1'b0);
      32'h22: return mk(a, fe_pkg::OP_IMM, 5'd0, 5'd0, 5'd0, 32'd0, 1'b1, 1'b0, 1'b1);
      32'h24: return mk(a, fe_pkg::LUI, 5'd5, 5'd0, 5'd0, 32'd0, 1'b0, 1'b0, 1'b0);
      default: begin
        $display("no expected decode for address %h", a);
        other_errors++;
        return nop_slot(a);
      end
    endcase
  endfunction

  task automatic add_row(input logic [31:0] pc, input logic upd, input logic [31:0] tgt);
    row_t r;
    r.pc = pc;
    r.upd = upd;
    r.pc_in = tgt;
    r.exp = upd ? nop_slot(pc) : exp_at(pc);
    rows.push_back(r);
  endtask

  task automatic check_pc(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[FAIL] %0t pc_out %h, expected %h", $time, act, exp);
      value_errors++;
    end
  endtask

  task automatic check_decoded(input fe_pkg::decoded_t exp, input fe_pkg::decoded_t act);
    if (act !== exp) begin
      $display("[FAIL] %0t decode at pc %h: op %h rd %0d rs1 %0d rs2 %0d imm %h c%b br%b il%b",
               $time, act.pc, act.opcode, act.rd, act.rs1, act.rs2, act.imm,
               act.compressed, act.br, act.illegal);
      $display("[FAIL] %0t   expected pc %h: op %h rd %0d rs1 %0d rs2 %0d imm %h c%b br%b il%b",
               $time, exp.pc, exp.opcode, exp.rd, exp.rs1, exp.rs2, exp.imm,
               exp.compressed, exp.br, exp.illegal);
      value_errors++;
    end
  endtask

  initial begin : watchdog
    for (int i = 0; i < 400; i++) begin
      @(posedge clk);
    end
    $display("timeout, the run did not finish in 400 cycles");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0]      targets [8];
    logic [31:0]      rnd_pc;
    fe_pkg::decoded_t act;
    int               wait_cnt;
    int               n;

    clk          = 1'b0;
    rst_n        = 1'b0;
    mem_rd       = 32'd0;
    pc_in        = 32'd0;
    pc_update    = 1'b0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'h1a6a0fe9));
    load_program();

    targets = '{32'h00, 32'h04, 32'h06, 32'h08, 32'h0a, 32'h0c, 32'h0e, 32'h24};
    rnd_pc  = targets[$urandom % 8];

    // straight run, then a redirect that beats the jal at 0x28
    add_row(32'h00, 1'b0, 32'd0);
    add_row(32'h04, 1'b0, 32'd0);
    add_row(32'h06, 1'b0, 32'd0);
    add_row(32'h08, 1'b0, 32'd0);
    add_row(32'h0a, 1'b0, 32'd0);
    add_row(32'h0c, 1'b0, 32'd0);
    add_row(32'h0e, 1'b0, 32'd0);
    add_row(32'h12, 1'b0, 32'd0);
    add_row(32'h1e, 1'b0, 32'd0);
    add_row(32'h22, 1'b0, 32'd0);
    add_row(32'h24, 1'b0, 32'd0);
    add_row(32'h28, 1'b1, 32'h0c);
    add_row(32'h0c, 1'b0, 32'd0);
    add_row(32'h0e, 1'b0, 32'd0);
    add_row(32'h12, 1'b0, 32'd0);
    add_row(32'h1e, 1'b0, 32'd0);
    add_row(32'h22, 1'b0, 32'd0);
    add_row(32'h24, 1'b0, 32'd0);
    add_row(32'h28, 1'b1, rnd_pc); // random target
    add_row(rnd_pc, 1'b0, 32'd0);
    n = rows.size();

    repeat (16) @(posedge clk);
    #2 rst_n = 1'b1;
    // boot address must show on pc_out once out of reset
    wait_cnt = 0;
    while (pc_out !== 32'h0000_0000 && wait_cnt < 10) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (pc_out !== 32'h0000_0000) begin
      $display("pc_out never showed the boot address after reset");
      other_errors++;
    end

    for (int c = 0; c < n + 2; c++) begin
      if (c < n) begin
        check_pc(rows[c].pc, pc_out);
        pc_update = rows[c].upd;
        pc_in     = rows[c].pc_in;
      end else begin
        pc_update = 1'b0;
        pc_in     = 32'd0;
      end
      mem_rd = fetch_window(pc_out);
      if (c >= 2) begin
        act.pc         = dec_pc;
        act.opcode     = fe_pkg::opcode_e'(dec_opcode);
        act.rd         = dec_rd;
        act.rs1        = dec_rs1;
        act.rs2        = dec_rs2;
        act.imm        = dec_imm;
        act.compressed = dec_compressed;
        act.br         = dec_br;
        act.illegal    = dec_illegal;
        check_decoded(rows[c-2].exp, act);
      end
      @(posedge clk);
      #2;
    end

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : fetch_frontend_tb

//--- list.f
+incdir+logic
+incdir+bench
logic/fe_pkg.sv
logic/if_id_if.sv
logic/jump_predecoder.sv
logic/if_stage.sv
logic/c_expander.sv
logic/id_stage.sv
logic/fetch_frontend.sv
bench/fetch_frontend_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f list.f \
  --top-module fetch_frontend_tb \
  -o fetch_frontend_sim

./obj_dir/fetch_frontend_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  exit 1
fi
exit 0
